/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := dmem_tb
RTL_TOP   := dmem_top
FILELIST  := dmem_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/dmem_tb.sv */
// Data-memory testbench: stimulus, shadow memory, reference model, response checker, timeout
`timescale 1ns/10ps

module dmem_tb;

  localparam int MEM_WORDS  = 64;
  localparam int HALF_BYTES = MEM_WORDS * 4;  // Address half owned by each port
  localparam int N_ROUNDS   = 12;
  localparam int N_RANDOM   = 100;            // Per port
  // Fill, extend, lanes, misaligned, contention, random
  localparam int TXN_TOTAL = MEM_WORDS + 30 + 7 + 12 + 2 * N_ROUNDS + 2 * N_RANDOM;
  localparam int TIMEOUT_CYCLES = TXN_TOTAL * 12 + 1000;  // Under 12 cycles each, plus slack

  logic clk, rst;
  lsu_pkg::lsu_req_t  req0, req1;
  lsu_pkg::lsu_resp_t o_resp0, o_resp1;
  logic o_busy0, o_busy1;

  logic [7:0] shadow [MEM_WORDS * 8];  // Byte image of the RAM
  lsu_pkg::lsu_resp_t exp_q0 [$];      // Expected responses, oldest first
  lsu_pkg::lsu_resp_t exp_q1 [$];
  logic [1:0] after_resp = '0;         // Response seen last cycle, per port
  integer seed;
  int checks = 0;
  int errors = 0;
  int cycles = 0;
  string test_name = "reset";

  tb_clock u_clock (.o_clk(clk), .o_rst(rst));

  dmem_top #(.MEM_WORDS(MEM_WORDS)) DUT (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_req0  (req0),
    .i_req1  (req1),
    .o_resp0 (o_resp0),
    .o_resp1 (o_resp1),
    .o_busy0 (o_busy0),
    .o_busy1 (o_busy1)
  );

  function automatic int access_size(lsu_pkg::mem_op_e op);
    case (op)
      lsu_pkg::OP_LB, lsu_pkg::OP_LBU: return 1;
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU: return 2;
      lsu_pkg::OP_LW, lsu_pkg::OP_LWU: return 4;
      lsu_pkg::OP_LD:                  return 8;
      default:                         return 0;  // No access
    endcase
  endfunction

  // Expected response from the shadow image
  function automatic lsu_pkg::lsu_resp_t predict(logic wr, lsu_pkg::mem_op_e op,
                                                 bus_pkg::addr_t addr);
    lsu_pkg::lsu_resp_t r;
    int size;
    int base;
    logic signed_op;
    r = '0;
    r.valid = 1'b1;
    size = access_size(op);
    base = int'(addr % (MEM_WORDS * 8));
    signed_op = (op == lsu_pkg::OP_LB) || (op == lsu_pkg::OP_LH) || (op == lsu_pkg::OP_LW);
    if (size == 0) return r;
    r.misaligned = (addr % size) != 0;
    if (r.misaligned || wr) return r;  // Stores and dropped accesses read zero
    for (int i = 0; i < size; i++) r.rdata[8*i +: 8] = shadow[base + i];  // Little endian
    if (signed_op && r.rdata[8*size-1]) begin
      for (int i = 8 * size; i < 64; i++) r.rdata[i] = 1'b1;  // Sign fill
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Called at a falling edge while the port is idle
  task automatic send(input int p, input logic wr, input lsu_pkg::mem_op_e op,
                      input bus_pkg::addr_t addr, input bus_pkg::data_t wdata);
    lsu_pkg::lsu_req_t r;
    lsu_pkg::lsu_resp_t e;
    int base;
    r = {1'b1, wr, op, addr, wdata};
    e = predict(wr, op, addr);
    base = int'(addr % (MEM_WORDS * 8));
    if (p == 0) begin
      exp_q0.push_back(e);
      req0 = r;
    end else begin
      exp_q1.push_back(e);
      req1 = r;
    end
    if (wr && !e.misaligned) begin  // Shadow follows the store at issue
      for (int i = 0; i < access_size(op); i++) shadow[base + i] = wdata[8*i +: 8];
    end
    @(negedge clk);
    if (p == 0) req0.valid = 1'b0;
    else req1.valid = 1'b0;
  endtask

  task automatic idle_wait(input int p);
    while ((p == 0) ? o_busy0 : o_busy1) @(negedge clk);
  endtask

  task automatic request(input int p, input logic wr, input lsu_pkg::mem_op_e op,
                         input int addr, input bus_pkg::data_t wdata);
    idle_wait(p);
    send(p, wr, op, bus_pkg::addr_t'(addr), wdata);
  endtask

  task automatic fill_half(input int p);
    bus_pkg::addr_t a;
    for (int w = 0; w < MEM_WORDS / 2; w++) begin
      a = bus_pkg::addr_t'(p * HALF_BYTES + 8 * w);
      request(p, 1'b1, lsu_pkg::OP_LD, int'(a), {a ^ 32'h5a5a_0000, ~a});  // Whole address
    end
  endtask

  task automatic random_port(input int p);
    logic [31:0] r;
    lsu_pkg::mem_op_e op;
    int size;
    int off;
    repeat (N_RANDOM) begin
      op = lsu_pkg::mem_op_e'(3'({$random(seed)} % 7));  // Any code but OP_NONE
      size = access_size(op);
      off = int'({$random(seed)} % HALF_BYTES);
      off = off - off % size;  // Aligned
      r = $random(seed);
      request(p, r[0], op, p * HALF_BYTES + off, {$random(seed), $random(seed)});
    end
  endtask

  task automatic watch_port(input int p, input lsu_pkg::lsu_resp_t resp, input logic busy);
    lsu_pkg::lsu_resp_t e;
    if (after_resp[p]) check($sformatf("%s port%0d busy", test_name, p), 64'd0, 64'(busy));
    after_resp[p] = resp.valid;
    if (resp.valid) begin
      if ((p == 0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0)) begin
        errors++;
        $display("Port %0d answered with no request outstanding", p);
      end else begin
        e = (p == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
        check($sformatf("%s port%0d rdata", test_name, p), e.rdata, resp.rdata);
        check($sformatf("%s port%0d misaligned", test_name, p),
              64'(e.misaligned), 64'(resp.misaligned));
      end
    end
  endtask

  // Outputs are registered, stable at the falling edge
  always @(negedge clk) begin
    if (rst) begin
      watch_port(0, o_resp0, o_busy0);
      watch_port(1, o_resp1, o_busy1);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a request never completed", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    req0 = '0;
    req1 = '0;
    seed = 32'h3c59_56bf;
    @(posedge rst);
    @(negedge clk);
    test_name = "fill";
    fork
      fill_half(0);
      fill_half(1);
    join
    test_name = "extend";
    request(0, 1'b1, lsu_pkg::OP_LD, 0, 64'h80ff_7f01_c3a5_5a3c);
    for (int k = 0; k < 7; k++) begin
      for (int off = 0; off < 8; off += access_size(lsu_pkg::mem_op_e'(3'(k)))) begin
        request(0, 1'b0, lsu_pkg::mem_op_e'(3'(k)), off, '0);
      end
    end
    test_name = "lanes";  // Upper wdata bytes must not leak
    request(0, 1'b1, lsu_pkg::OP_LD, 16, 64'h0123_4567_89ab_cdef);
    request(0, 1'b1, lsu_pkg::OP_LB, 19, 64'hffff_ffff_ffff_ffaa);
    request(0, 1'b0, lsu_pkg::OP_LD, 16, '0);
    request(0, 1'b1, lsu_pkg::OP_LHU, 22, 64'hdead_beef_cafe_5566);
    request(0, 1'b0, lsu_pkg::OP_LD, 16, '0);
    request(0, 1'b1, lsu_pkg::OP_LW, 16, 64'h7777_7777_1234_5678);
    request(0, 1'b0, lsu_pkg::OP_LD, 16, '0);
    test_name = "misaligned";
    request(0, 1'b0, lsu_pkg::OP_LH, 25, '0);
    request(0, 1'b0, lsu_pkg::OP_LHU, 27, '0);
    request(0, 1'b0, lsu_pkg::OP_LW, 26, '0);
    request(0, 1'b0, lsu_pkg::OP_LWU, 29, '0);
    request(0, 1'b0, lsu_pkg::OP_LD, 28, '0);
    request(0, 1'b1, lsu_pkg::OP_LH, 25, '1);
    request(0, 1'b1, lsu_pkg::OP_LW, 30, '1);
    request(0, 1'b1, lsu_pkg::OP_LD, 27, '1);
    request(0, 1'b0, lsu_pkg::OP_LD, 24, '0);
    request(0, 1'b0, lsu_pkg::OP_NONE, 33, '0);
    request(0, 1'b1, lsu_pkg::OP_NONE, 24, '1);
    request(0, 1'b0, lsu_pkg::OP_LD, 24, '0);
    test_name = "contention";
    for (int r = 0; r < N_ROUNDS; r++) begin
      fork
        idle_wait(0);
        idle_wait(1);
      join
      fork  // Same falling edge on both ports
        send(0, ~r[0], lsu_pkg::OP_LD, bus_pkg::addr_t'(64 + 8 * (r / 2)),
             {$random(seed), $random(seed)});
        send(1, ~r[0], r[0] ? lsu_pkg::OP_LWU : lsu_pkg::OP_LW,
             bus_pkg::addr_t'(HALF_BYTES + 68 + 8 * (r / 2)), {$random(seed), $random(seed)});
      join
    end
    test_name = "random";
    fork
      random_port(0);
      random_port(1);
    join
    fork
      idle_wait(0);
      idle_wait(1);
    join
    @(negedge clk);  // Last busy check
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      errors++;
      $display("Responses missing: %0d on port 0, %0d on port 1", exp_q0.size(), exp_q1.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
// Testbench clock and active-low reset generator
`timescale 1ns/10ps

module tb_clock (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;  // 4 ns period
  end

  initial begin
    o_rst = 1'b0;
    repeat (4) @(negedge o_clk);  // Four rising edges in reset
    o_rst = 1'b1;                 // Released on a falling edge
  end

endmodule

/* dmem_top.f */
hdl/bus_pkg.sv
hdl/lsu_pkg.sv
hdl/load_store_unit.sv
hdl/apb_arbiter.sv
hdl/data_ram.sv
hdl/dmem_top.sv
bench/tb_clock.sv
bench/dmem_tb.sv

/* hdl/apb_arbiter.sv */
// Two-master to one-slave APB arbiter with round-robin grant held per transfer
`timescale 1ns/10ps

module apb_arbiter (
  input  logic              i_clk,
  input  logic              i_rst,
  input  bus_pkg::apb_req_t i_m0_req,
  input  bus_pkg::apb_req_t i_m1_req,
  input  bus_pkg::apb_rsp_t i_s_rsp,
  output bus_pkg::apb_rsp_t o_m0_rsp,
  output bus_pkg::apb_rsp_t o_m1_rsp,
  output bus_pkg::apb_req_t o_s_req
);

  logic lock_q;     // Grant frozen after setup
  logic gnt_q;      // Locked owner
  logic last_q;     // Master served last
  logic pick;       // Fresh choice while unlocked
  logic gnt;        // Effective owner this cycle
  logic xfer_done;  // Access cycle completes

  bus_pkg::apb_req_t sel_req;

  // Both asking goes to the one not served last
  always_comb begin
    if (i_m0_req.psel && i_m1_req.psel) begin
      pick = ~last_q;
    end else begin
      pick = i_m1_req.psel;
    end
  end

  assign gnt = lock_q ? gnt_q : pick;

  // A master waiting in access gets a fresh setup cycle at the slave
  always_comb begin
    sel_req         = gnt ? i_m1_req : i_m0_req;
    o_s_req         = sel_req;
    o_s_req.penable = lock_q & sel_req.penable;
  end

  assign xfer_done = o_s_req.penable & i_s_rsp.pready;

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      lock_q <= 1'b0;
      gnt_q  <= 1'b0;
      last_q <= 1'b1;  // Port 0 first
    end else if (!lock_q) begin
      if (i_m0_req.psel || i_m1_req.psel) begin
        lock_q <= 1'b1;  // Setup went out this cycle
        gnt_q  <= pick;
      end
    end else if (xfer_done) begin
      lock_q <= 1'b0;
      last_q <= gnt_q;
    end
  end

  // Loser sees no pready and holds its transfer
  always_comb begin
    o_m0_rsp = i_s_rsp;
    o_m1_rsp = i_s_rsp;
    if (gnt) begin
      o_m0_rsp.pready  = 1'b0;
      o_m0_rsp.pslverr = 1'b0;
    end else begin
      o_m1_rsp.pready  = 1'b0;
      o_m1_rsp.pslverr = 1'b0;
    end
  end

  // Slave select exactly when a master asks or owns the bus
  a_psel_granted: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_s_req.psel == (lock_q || i_m0_req.psel || i_m1_req.psel));

endmodule

/* hdl/bus_pkg.sv */
// APB address, data and strobe types; APB request and response structs
package bus_pkg;

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [63:0] data_t;  // One bus word
  typedef logic [7:0]  strb_t;  // One bit per byte lane

  // Master to slave, 107 bits
  typedef struct packed {
    logic  psel;     // Slave selected
    logic  penable;  // Access phase
    logic  pwrite;   // Write transfer
    addr_t paddr;    // Word-aligned address
    data_t pwdata;   // Lane-steered write data
    strb_t pstrb;    // Byte enables
  } apb_req_t;

  // Slave to master, 66 bits
  typedef struct packed {
    logic  pready;   // Transfer done
    data_t prdata;   // Full read word
    logic  pslverr;  // Error, never raised by the RAM
  } apb_rsp_t;

endpackage

/* hdl/data_ram.sv */
// APB slave RAM, byte strobes, zero wait states
`timescale 1ns/10ps

module data_ram #(
  parameter int MEM_WORDS = 64  // Depth in 64-bit words
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  bus_pkg::apb_req_t i_apb_req,
  output bus_pkg::apb_rsp_t o_apb_rsp
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  bus_pkg::data_t   mem [MEM_WORDS];
  logic [IDX_W-1:0] word_idx;  // Word address, wraps at depth
  logic             access;    // Second APB phase

  assign word_idx = IDX_W'(i_apb_req.paddr[31:3] % MEM_WORDS);
  assign access   = i_apb_req.psel & i_apb_req.penable;

  // Byte writes at end of access
  always_ff @(posedge i_clk) begin
    if (access && i_apb_req.pwrite) begin
      for (int b = 0; b < 8; b++) begin
        if (i_apb_req.pstrb[b]) begin
          mem[word_idx][b*8 +: 8] <= i_apb_req.pwdata[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    o_apb_rsp.pready  = access;          // No wait states
    o_apb_rsp.prdata  = mem[word_idx];   // Combinational read
    o_apb_rsp.pslverr = 1'b0;
  end

  a_penable_psel: assert property (@(posedge i_clk) disable iff (!i_rst)
    i_apb_req.penable |-> i_apb_req.psel);

endmodule

/* hdl/dmem_top.sv */
// Data-memory top: two load/store units, APB arbiter, shared RAM
`timescale 1ns/10ps

module dmem_top #(
  parameter int MEM_WORDS = 64  // RAM depth in words
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  lsu_pkg::lsu_req_t  i_req0,
  input  lsu_pkg::lsu_req_t  i_req1,
  output lsu_pkg::lsu_resp_t o_resp0,
  output lsu_pkg::lsu_resp_t o_resp1,
  output logic               o_busy0,
  output logic               o_busy1
);

  bus_pkg::apb_req_t m0_req, m1_req, s_req;  // Hart side and RAM side
  bus_pkg::apb_rsp_t m0_rsp, m1_rsp, s_rsp;

  load_store_unit u_lsu0 (  // Hart 0
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (i_req0),
    .i_apb_rsp (m0_rsp),
    .o_resp    (o_resp0),
    .o_busy    (o_busy0),
    .o_apb_req (m0_req)
  );

  load_store_unit u_lsu1 (  // Hart 1
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (i_req1),
    .i_apb_rsp (m1_rsp),
    .o_resp    (o_resp1),
    .o_busy    (o_busy1),
    .o_apb_req (m1_req)
  );

  apb_arbiter u_arb (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_m0_req (m0_req),
    .i_m1_req (m1_req),
    .i_s_rsp  (s_rsp),
    .o_m0_rsp (m0_rsp),
    .o_m1_rsp (m1_rsp),
    .o_s_req  (s_req)
  );

  data_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_apb_req (s_req),
    .o_apb_rsp (s_rsp)
  );

endmodule

/* hdl/load_store_unit.sv */
// Per-hart load/store unit: APB master FSM, strobe build, lane steering, load extension
`timescale 1ns/10ps

module load_store_unit (
  input  logic               i_clk,
  input  logic               i_rst,
  input  lsu_pkg::lsu_req_t  i_req,
  input  bus_pkg::apb_rsp_t  i_apb_rsp,
  output lsu_pkg::lsu_resp_t o_resp,
  output logic               o_busy,
  output bus_pkg::apb_req_t  o_apb_req
);

  lsu_pkg::lsu_state_e state_q, state_d;

  bus_pkg::strb_t   lane_mask;   // Unshifted strobe for the width
  logic [2:0]       align_mask;  // Low address bits that must be zero
  logic             req_mis;     // Incoming request misaligned
  logic             req_skip;    // Answer without a bus transfer

  logic             wr_en_q;     // Latched request payload
  lsu_pkg::mem_op_e op_q;
  logic [2:0]       off_q;       // Byte offset in the word
  bus_pkg::addr_t   paddr_q;
  bus_pkg::data_t   wdata_q;
  bus_pkg::strb_t   strb_q;
  bus_pkg::data_t   rdata_q;
  logic             mis_q;

  bus_pkg::data_t   load_shift;  // Loaded bytes moved to lane 0
  bus_pkg::data_t   load_ext;    // After sign or zero extension

  // Width decode of the incoming access code
  always_comb begin
    case (i_req.op)
      lsu_pkg::OP_LB, lsu_pkg::OP_LBU: begin
        lane_mask  = 8'h01;
        align_mask = 3'd0;
      end
      lsu_pkg::OP_LH, lsu_pkg::OP_LHU: begin
        lane_mask  = 8'h03;
        align_mask = 3'd1;
      end
      lsu_pkg::OP_LW, lsu_pkg::OP_LWU: begin
        lane_mask  = 8'h0f;
        align_mask = 3'd3;
      end
      lsu_pkg::OP_LD: begin
        lane_mask  = 8'hff;
        align_mask = 3'd7;
      end
      default: begin  // OP_NONE, no lanes
        lane_mask  = 8'h00;
        align_mask = 3'd0;
      end
    endcase
  end

  assign req_mis  = |(i_req.addr[2:0] & align_mask);
  assign req_skip = (i_req.op == lsu_pkg::OP_NONE) || req_mis;

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::IDLE:   if (i_req.valid) state_d = req_skip ? lsu_pkg::RESP : lsu_pkg::SETUP;
      lsu_pkg::SETUP:  state_d = lsu_pkg::ACCESS;          // Setup is always one cycle
      lsu_pkg::ACCESS: if (i_apb_rsp.pready) state_d = lsu_pkg::RESP;  // Wait out grant
      default:         state_d = lsu_pkg::IDLE;            // RESP lasts one cycle
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      state_q <= lsu_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Returned word down to lane 0, then extend by code
  assign load_shift = i_apb_rsp.prdata >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      lsu_pkg::OP_LB:  load_ext = {{56{load_shift[7]}}, load_shift[7:0]};
      lsu_pkg::OP_LBU: load_ext = {56'd0, load_shift[7:0]};
      lsu_pkg::OP_LH:  load_ext = {{48{load_shift[15]}}, load_shift[15:0]};
      lsu_pkg::OP_LHU: load_ext = {48'd0, load_shift[15:0]};
      lsu_pkg::OP_LW:  load_ext = {{32{load_shift[31]}}, load_shift[31:0]};
      lsu_pkg::OP_LWU: load_ext = {32'd0, load_shift[31:0]};
      default:         load_ext = load_shift;  // ld
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (state_q == lsu_pkg::IDLE && i_req.valid) begin
      wr_en_q <= i_req.wr_en;
      op_q    <= i_req.op;
      off_q   <= i_req.addr[2:0];
      paddr_q <= {i_req.addr[31:3], 3'b000};           // Word aligned
      wdata_q <= i_req.wdata << {i_req.addr[2:0], 3'b000};  // Into its lanes
      strb_q  <= lane_mask << i_req.addr[2:0];
      mis_q   <= req_mis;
      rdata_q <= '0;                                   // Stores and skips read zero
    end else if (state_q == lsu_pkg::ACCESS && i_apb_rsp.pready && !wr_en_q) begin
      rdata_q <= load_ext;
    end
  end

  assign o_busy = (state_q != lsu_pkg::IDLE);

  always_comb begin
    o_resp.valid      = (state_q == lsu_pkg::RESP);
    o_resp.rdata      = rdata_q;
    o_resp.misaligned = mis_q;
  end

  always_comb begin
    o_apb_req.psel    = (state_q == lsu_pkg::SETUP) || (state_q == lsu_pkg::ACCESS);
    o_apb_req.penable = (state_q == lsu_pkg::ACCESS);
    o_apb_req.pwrite  = wr_en_q;
    o_apb_req.paddr   = paddr_q;  // Held from setup to end of access
    o_apb_req.pwdata  = wdata_q;
    o_apb_req.pstrb   = strb_q;
  end

  // Caller must wait for o_busy to drop
  a_no_req_busy: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_busy |-> !i_req.valid);

  a_strb_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_apb_req.psel |-> (o_apb_req.pstrb != '0));

endmodule

/* hdl/lsu_pkg.sv */
// Access-code enum, load/store request and response structs, LSU FSM states
package lsu_pkg;

  // RISC-V width/sign code, stores look only at the width
  typedef enum logic [2:0] {
    OP_LB   = 3'd0,
    OP_LBU  = 3'd1,
    OP_LH   = 3'd2,
    OP_LHU  = 3'd3,
    OP_LW   = 3'd4,
    OP_LWU  = 3'd5,
    OP_LD   = 3'd6,
    OP_NONE = 3'd7
  } mem_op_e;

  typedef struct packed {
    logic           valid;  // One-cycle request strobe
    logic           wr_en;  // Store when set
    mem_op_e        op;     // Width and sign
    bus_pkg::addr_t addr;   // Byte address
    bus_pkg::data_t wdata;  // Store value in low bytes
  } lsu_req_t;

  typedef struct packed {
    logic           valid;       // One-cycle response strobe
    bus_pkg::data_t rdata;       // Extended load value
    logic           misaligned;  // Access dropped
  } lsu_resp_t;

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS, RESP} lsu_state_e;

endpackage
